//--- hdl/rv_core_defs.svh
// Shared width and opcode constants for the RV32I execute slice, included by each RTL file.
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// datapath and register index widths.
`define RV_XLEN   32
`define RV_NREG_W 5

// major opcodes, instr[6:0].
`define RV_OPC_OP     7'b0110011
`define RV_OPC_OP_IMM 7'b0010011
`define RV_OPC_BRANCH 7'b1100011
`define RV_OPC_JAL    7'b1101111
`define RV_OPC_JALR   7'b1100111
`define RV_OPC_STORE  7'b0100011
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_AUIPC  7'b0010111

`endif

//--- hdl/rv_core_pkg.sv
// Enum types shared by decode, execute and the top level of the RV32I slice; import where used.
`default_nettype none

package rv_core_pkg;

  // decoded instruction class.
  typedef enum logic [2:0] {
    CLS_ALU     = 3'd0,
    CLS_BRANCH  = 3'd1,
    CLS_JAL     = 3'd2,
    CLS_JALR    = 3'd3,
    CLS_STORE   = 3'd4,
    CLS_ILLEGAL = 3'd5
  } insn_class_e;

  // alu operation.
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLT  = 4'd2,
    ALU_SLTU = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_OR   = 4'd5,
    ALU_AND  = 4'd6,
    ALU_SLL  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SRA  = 4'd9
  } alu_op_e;

  // where an alu operand comes from.
  typedef enum logic [1:0] {
    SRC_REG  = 2'd0,
    SRC_IMM  = 2'd1,
    SRC_ZERO = 2'd2,
    SRC_PC   = 2'd3
  } opnd_src_e;

  // branch condition, same encoding as funct3.
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } br_cond_e;

endpackage

`default_nettype wire

//--- hdl/rv_decode.sv
// Decodes an accepted instruction word into the ID/EX register; instantiated by the core top.
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defs.svh"

module rv_decode (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  logic                         instr_valid_i,
  input  logic [31:0]                  instr_i,
  input  logic [`RV_XLEN-1:0]          pc_i,
  input  logic                         stall_i,
  input  logic                         flush_i,
  output logic                         idex_valid_o,
  output rv_core_pkg::insn_class_e     idex_class_o,
  output rv_core_pkg::alu_op_e         idex_alu_op_o,
  output rv_core_pkg::br_cond_e        idex_br_cond_o,
  output rv_core_pkg::opnd_src_e       idex_rs1_src_o,
  output rv_core_pkg::opnd_src_e       idex_rs2_src_o,
  output logic [`RV_NREG_W-1:0]        idex_rs1_addr_o,
  output logic [`RV_NREG_W-1:0]        idex_rs2_addr_o,
  output logic [`RV_NREG_W-1:0]        idex_rd_addr_o,
  output logic                         idex_we_rd_o,
  output logic [`RV_XLEN-1:0]          idex_imm_o,
  output logic [`RV_XLEN-1:0]          idex_pc_o,
  output logic [1:0]                   idex_st_width_o,
  output logic                         illegal_o
);
  import rv_core_pkg::*;

  logic [6:0]          opcode;
  logic [2:0]          f3;
  logic [6:0]          f7;
  logic                shift_ok;
  logic                accept;
  insn_class_e         dec_class;
  alu_op_e             dec_alu_op;
  opnd_src_e           dec_rs1_src;
  opnd_src_e           dec_rs2_src;
  logic                dec_we_rd;
  logic [`RV_XLEN-1:0] dec_imm;

  function automatic alu_op_e alu_from_f3(input logic [2:0] fn3, input logic alt);
    alu_op_e op;
    case (fn3)
      3'd0:    op = alt ? ALU_SUB : ALU_ADD;
      3'd1:    op = ALU_SLL;
      3'd2:    op = ALU_SLT;
      3'd3:    op = ALU_SLTU;
      3'd4:    op = ALU_XOR;
      3'd5:    op = alt ? ALU_SRA : ALU_SRL;
      3'd6:    op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode   = instr_i[6:0];
  assign f3       = instr_i[14:12];
  assign f7       = instr_i[31:25];
  assign shift_ok = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd5));
  assign accept   = instr_valid_i && !stall_i && !flush_i;

  always_comb begin
    dec_class   = CLS_ILLEGAL;
    dec_alu_op  = ALU_ADD;
    dec_rs1_src = SRC_REG;
    dec_rs2_src = SRC_IMM;
    dec_we_rd   = 1'b0;
    dec_imm     = {{20{instr_i[31]}}, instr_i[31:20]};
    case (opcode)
      `RV_OPC_OP: begin
        if ((f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5))) begin
          dec_class = CLS_ALU;
        end
        dec_alu_op  = alu_from_f3(f3, f7[5]);
        dec_rs2_src = SRC_REG;
        dec_we_rd   = 1'b1;
      end
      `RV_OPC_OP_IMM: begin
        // only the shifts carry a funct7 field.
        if (!(f3 == 3'd1 || f3 == 3'd5) || shift_ok) begin
          dec_class = CLS_ALU;
        end
        dec_alu_op = alu_from_f3(f3, f7[5] && (f3 == 3'd5));
        dec_we_rd  = 1'b1;
      end
      `RV_OPC_LUI, `RV_OPC_AUIPC: begin
        dec_class   = CLS_ALU;
        dec_rs1_src = (opcode == `RV_OPC_LUI) ? SRC_ZERO : SRC_PC;
        dec_imm     = {instr_i[31:12], 12'b0};
        dec_we_rd   = 1'b1;
      end
      `RV_OPC_JAL: begin
        dec_class   = CLS_JAL;
        dec_rs1_src = SRC_PC;
        dec_imm     = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};
        dec_we_rd   = 1'b1;
      end
      `RV_OPC_JALR: begin
        if (f3 == 3'd0) begin
          dec_class = CLS_JALR;
        end
        dec_we_rd = 1'b1;
      end
      `RV_OPC_BRANCH: begin
        if (f3 != 3'd2 && f3 != 3'd3) begin
          dec_class = CLS_BRANCH;
        end
        dec_rs2_src = SRC_REG;
        dec_imm     = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
      end
      `RV_OPC_STORE: begin
        if (f3 <= 3'd2) begin
          dec_class = CLS_STORE;
        end
        dec_imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
      end
      default: begin
        // loads and everything else fall out as illegal.
        dec_class = CLS_ILLEGAL;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      idex_valid_o <= 1'b0;
      illegal_o    <= 1'b0;
    end else begin
      illegal_o <= accept && (dec_class == CLS_ILLEGAL);
      if (flush_i) begin
        idex_valid_o <= 1'b0;
      end else if (!stall_i) begin
        idex_valid_o <= instr_valid_i && (dec_class != CLS_ILLEGAL);
      end
    end
  end

  // payload follows the valid bit and holds with it.
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      idex_class_o    <= dec_class;
      idex_alu_op_o   <= dec_alu_op;
      idex_br_cond_o  <= br_cond_e'(f3);
      idex_rs1_src_o  <= dec_rs1_src;
      idex_rs2_src_o  <= dec_rs2_src;
      idex_rs1_addr_o <= instr_i[19:15];
      idex_rs2_addr_o <= instr_i[24:20];
      idex_rd_addr_o  <= instr_i[11:7];
      idex_we_rd_o    <= dec_we_rd;
      idex_imm_o      <= dec_imm;
      idex_pc_o       <= pc_i;
      idex_st_width_o <= f3[1:0];
    end
  end

endmodule

`default_nettype wire

//--- hdl/rv_regfile.sv
// Integer register file with two combinational reads and one write port; used by the core top.
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defs.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic [`RV_NREG_W-1:0] rs1_addr_i,
  input  logic [`RV_NREG_W-1:0] rs2_addr_i,
  output logic [`RV_XLEN-1:0]   rs1_data_o,
  output logic [`RV_XLEN-1:0]   rs2_data_o,
  input  logic                  we_i,
  input  logic [`RV_NREG_W-1:0] rd_addr_i,
  input  logic [`RV_XLEN-1:0]   rd_data_i
);

  // x0 has no storage.
  logic [`RV_XLEN-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (we_i && (rd_addr_i != '0)) begin
      regs[rd_addr_i] <= rd_data_i;
    end
  end

  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

//--- hdl/rv_execute.sv
// Execute stage: operand select, forwarding, ALU, branch resolve, store request and EX/WB register.
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defs.svh"

module rv_execute (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       idex_valid_i,
  input  rv_core_pkg::insn_class_e   idex_class_i,
  input  rv_core_pkg::alu_op_e       idex_alu_op_i,
  input  rv_core_pkg::br_cond_e      idex_br_cond_i,
  input  rv_core_pkg::opnd_src_e     idex_rs1_src_i,
  input  rv_core_pkg::opnd_src_e     idex_rs2_src_i,
  input  logic [`RV_NREG_W-1:0]      idex_rs1_addr_i,
  input  logic [`RV_NREG_W-1:0]      idex_rs2_addr_i,
  input  logic [`RV_NREG_W-1:0]      idex_rd_addr_i,
  input  logic                       idex_we_rd_i,
  input  logic [`RV_XLEN-1:0]        idex_imm_i,
  input  logic [`RV_XLEN-1:0]        idex_pc_i,
  input  logic [1:0]                 idex_st_width_i,
  input  logic [`RV_XLEN-1:0]        rs1_data_i,
  input  logic [`RV_XLEN-1:0]        rs2_data_i,
  input  logic                       stall_i,
  input  logic                       squash_i,
  output logic                       wb_valid_o,
  output logic [`RV_NREG_W-1:0]      wb_rd_o,
  output logic [`RV_XLEN-1:0]        wb_data_o,
  output logic                       take_o,
  output logic [`RV_XLEN-1:0]        target_o,
  output logic                       lsu_req_o,
  output logic [`RV_XLEN-1:0]        lsu_addr_o,
  output logic [`RV_XLEN-1:0]        lsu_wdata_o,
  output logic [1:0]                 lsu_width_o
);
  import rv_core_pkg::*;

  logic                fwd_rs1;
  logic                fwd_rs2;
  logic [`RV_XLEN-1:0] rs1_val;
  logic [`RV_XLEN-1:0] rs2_val;
  logic [`RV_XLEN-1:0] op1;
  logic [`RV_XLEN-1:0] op2;
  logic [`RV_XLEN-1:0] alu_res;
  logic [`RV_XLEN-1:0] result;
  logic                is_jump;
  logic                live;

  function automatic logic br_taken(input br_cond_e cond, input logic [`RV_XLEN-1:0] a,
                                    input logic [`RV_XLEN-1:0] b);
    logic t;
    case (cond)
      BR_BEQ:  t = (a == b);
      BR_BNE:  t = (a != b);
      BR_BLT:  t = ($signed(a) < $signed(b));
      BR_BGE:  t = ($signed(a) >= $signed(b));
      BR_BLTU: t = (a < b);
      BR_BGEU: t = (a >= b);
      default: t = 1'b0;
    endcase
    return t;
  endfunction

  // bypass from the instruction one ahead.
  assign fwd_rs1 = wb_valid_o && (wb_rd_o != '0) && (wb_rd_o == idex_rs1_addr_i);
  assign fwd_rs2 = wb_valid_o && (wb_rd_o != '0) && (wb_rd_o == idex_rs2_addr_i);
  assign rs1_val = fwd_rs1 ? wb_data_o : rs1_data_i;
  assign rs2_val = fwd_rs2 ? wb_data_o : rs2_data_i;

  always_comb begin
    case (idex_rs1_src_i)
      SRC_REG:  op1 = rs1_val;
      SRC_IMM:  op1 = idex_imm_i;
      SRC_PC:   op1 = idex_pc_i;
      default:  op1 = '0;
    endcase
    case (idex_rs2_src_i)
      SRC_REG:  op2 = rs2_val;
      SRC_IMM:  op2 = idex_imm_i;
      SRC_PC:   op2 = idex_pc_i;
      default:  op2 = '0;
    endcase
  end

  always_comb begin
    case (idex_alu_op_i)
      ALU_ADD:  alu_res = op1 + op2;
      ALU_SUB:  alu_res = op1 - op2;
      ALU_SLT:  alu_res = {31'b0, $signed(op1) < $signed(op2)};
      ALU_SLTU: alu_res = {31'b0, op1 < op2};
      ALU_XOR:  alu_res = op1 ^ op2;
      ALU_OR:   alu_res = op1 | op2;
      ALU_AND:  alu_res = op1 & op2;
      ALU_SLL:  alu_res = op1 << op2[4:0];
      ALU_SRL:  alu_res = op1 >> op2[4:0];
      ALU_SRA:  alu_res = $unsigned($signed(op1) >>> op2[4:0]);
      default:  alu_res = '0;
    endcase
  end

  assign is_jump = (idex_class_i == CLS_JAL) || (idex_class_i == CLS_JALR);
  assign live    = idex_valid_i && !squash_i;
  // link value for jumps.
  assign result  = is_jump ? (idex_pc_i + 32'd4) : alu_res;

  assign take_o   = live && (is_jump || ((idex_class_i == CLS_BRANCH) &&
                                         br_taken(idex_br_cond_i, rs1_val, rs2_val)));
  assign target_o = (idex_class_i == CLS_JALR) ? {alu_res[`RV_XLEN-1:1], 1'b0}
                                               : (idex_pc_i + idex_imm_i);

  // stays put under back-pressure since ID/EX holds.
  assign lsu_req_o   = live && (idex_class_i == CLS_STORE);
  assign lsu_addr_o  = alu_res;
  assign lsu_wdata_o = rs2_val;
  assign lsu_width_o = idex_st_width_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= live && idex_we_rd_i && !stall_i;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd_o   <= idex_rd_addr_i;
    wb_data_o <= result;
  end

endmodule

`default_nettype wire

//--- hdl/rv_pipe_ctrl.sv
// Pipe control: stall and flush priority, the redirect register and instruction ready.
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defs.svh"

module rv_pipe_ctrl (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                take_i,
  input  logic [`RV_XLEN-1:0] target_i,
  input  logic                lsu_bp_i,
  output logic                stall_o,
  output logic                flush_o,
  output logic                instr_ready_o,
  output logic                redirect_o,
  output logic [`RV_XLEN-1:0] redirect_pc_o
);

  // flush beats hold.
  assign flush_o       = redirect_o;
  assign stall_o       = lsu_bp_i && !redirect_o;
  assign instr_ready_o = !lsu_bp_i;

  // a branch held by back-pressure redirects once it is released.
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      redirect_o <= 1'b0;
    end else begin
      redirect_o <= take_i && !stall_o;
    end
  end

  always_ff @(posedge clk) begin
    if (take_i) begin
      redirect_pc_o <= target_i;
    end
  end

endmodule

`default_nettype wire

//--- hdl/rv_core_top.sv
// Top level of the RV32I execute slice; connects decode, register file, execute and control.
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defs.svh"

module rv_core_top (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  instr_valid_i,
  output logic                  instr_ready_o,
  input  logic [31:0]           instr_i,
  input  logic [`RV_XLEN-1:0]   pc_i,
  input  logic                  lsu_bp_i,
  output logic                  wb_valid_o,
  output logic [`RV_NREG_W-1:0] wb_rd_o,
  output logic [`RV_XLEN-1:0]   wb_data_o,
  output logic                  redirect_o,
  output logic [`RV_XLEN-1:0]   redirect_pc_o,
  output logic                  lsu_req_o,
  output logic [`RV_XLEN-1:0]   lsu_addr_o,
  output logic [`RV_XLEN-1:0]   lsu_wdata_o,
  output logic [1:0]            lsu_width_o,
  output logic                  illegal_o
);
  import rv_core_pkg::*;

  logic                  idex_valid;
  insn_class_e           idex_class;
  alu_op_e               idex_alu_op;
  br_cond_e              idex_br_cond;
  opnd_src_e             idex_rs1_src;
  opnd_src_e             idex_rs2_src;
  logic [`RV_NREG_W-1:0] idex_rs1_addr;
  logic [`RV_NREG_W-1:0] idex_rs2_addr;
  logic [`RV_NREG_W-1:0] idex_rd_addr;
  logic                  idex_we_rd;
  logic [`RV_XLEN-1:0]   idex_imm;
  logic [`RV_XLEN-1:0]   idex_pc;
  logic [1:0]            idex_st_width;
  logic [`RV_XLEN-1:0]   rs1_data;
  logic [`RV_XLEN-1:0]   rs2_data;
  logic                  stall;
  logic                  flush;
  logic                  take;
  logic [`RV_XLEN-1:0]   target;

  rv_decode u_decode (
    .clk(clk), .rst_n_i(rst_n_i), .instr_valid_i(instr_valid_i), .instr_i(instr_i),
    .pc_i(pc_i), .stall_i(stall), .flush_i(flush), .idex_valid_o(idex_valid),
    .idex_class_o(idex_class), .idex_alu_op_o(idex_alu_op), .idex_br_cond_o(idex_br_cond),
    .idex_rs1_src_o(idex_rs1_src), .idex_rs2_src_o(idex_rs2_src),
    .idex_rs1_addr_o(idex_rs1_addr), .idex_rs2_addr_o(idex_rs2_addr),
    .idex_rd_addr_o(idex_rd_addr), .idex_we_rd_o(idex_we_rd), .idex_imm_o(idex_imm),
    .idex_pc_o(idex_pc), .idex_st_width_o(idex_st_width), .illegal_o(illegal_o)
  );

  rv_regfile u_regfile (
    .clk(clk), .rs1_addr_i(idex_rs1_addr), .rs2_addr_i(idex_rs2_addr),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .we_i(wb_valid_o),
    .rd_addr_i(wb_rd_o), .rd_data_i(wb_data_o)
  );

  rv_execute u_execute (
    .clk(clk), .rst_n_i(rst_n_i), .idex_valid_i(idex_valid), .idex_class_i(idex_class),
    .idex_alu_op_i(idex_alu_op), .idex_br_cond_i(idex_br_cond),
    .idex_rs1_src_i(idex_rs1_src), .idex_rs2_src_i(idex_rs2_src),
    .idex_rs1_addr_i(idex_rs1_addr), .idex_rs2_addr_i(idex_rs2_addr),
    .idex_rd_addr_i(idex_rd_addr), .idex_we_rd_i(idex_we_rd), .idex_imm_i(idex_imm),
    .idex_pc_i(idex_pc), .idex_st_width_i(idex_st_width), .rs1_data_i(rs1_data),
    .rs2_data_i(rs2_data), .stall_i(stall), .squash_i(flush), .wb_valid_o(wb_valid_o),
    .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o), .take_o(take), .target_o(target),
    .lsu_req_o(lsu_req_o), .lsu_addr_o(lsu_addr_o), .lsu_wdata_o(lsu_wdata_o),
    .lsu_width_o(lsu_width_o)
  );

  rv_pipe_ctrl u_pipe_ctrl (
    .clk(clk), .rst_n_i(rst_n_i), .take_i(take), .target_i(target), .lsu_bp_i(lsu_bp_i),
    .stall_o(stall), .flush_o(flush), .instr_ready_o(instr_ready_o),
    .redirect_o(redirect_o), .redirect_pc_o(redirect_pc_o)
  );

endmodule

`default_nettype wire

//--- testbench/rv_core_checker.sv
// Testbench checker for the RV32I slice; compares DUT output events against queued expectations.
`timescale 1ns/1ps
`default_nettype none

module rv_core_checker (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        instr_ready_i,
  input  logic        wb_valid_i,
  input  logic [4:0]  wb_rd_i,
  input  logic [31:0] wb_data_i,
  input  logic        redirect_i,
  input  logic [31:0] redirect_pc_i,
  input  logic        lsu_req_i,
  input  logic [31:0] lsu_addr_i,
  input  logic [31:0] lsu_wdata_i,
  input  logic [1:0]  lsu_width_i,
  input  logic        lsu_bp_i,
  input  logic        illegal_i
);

  logic [36:0] wb_q [$];
  logic [65:0] st_q [$];
  logic [31:0] rd_q [$];
  logic [36:0] wb_e;
  logic [65:0] st_e;
  logic [65:0] held_req;
  logic        held;
  int          ill_cnt;
  int          errors;
  int          checks;

  initial begin
    held    = 1'b0;
    ill_cnt = 0;
    errors  = 0;
    checks  = 0;
  end

  task automatic expect_wb(input logic [4:0] rd, input logic [31:0] data);
    wb_q.push_back({rd, data});
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data,
                              input logic [1:0] width);
    st_q.push_back({width, addr, data});
  endtask

  task automatic expect_redirect(input logic [31:0] pc);
    rd_q.push_back(pc);
  endtask

  task automatic expect_illegal();
    ill_cnt++;
  endtask

  function automatic int pending();
    return wb_q.size() + st_q.size() + rd_q.size() + ill_cnt;
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic unexpected(input string what);
    errors++;
    $display("t=%0t unexpected %s with nothing expected", $time, what);
  endtask

  // outputs are settled at the falling edge.
  always @(negedge clk) begin
    if (rst_n_i) begin
      // no new instruction while the pipe is held.
      if (lsu_bp_i) begin
        compare("instr_ready_o", 32'd0, {31'b0, instr_ready_i});
      end
      if (wb_valid_i) begin
        if (wb_q.size() == 0) begin
          unexpected("writeback");
        end else begin
          wb_e = wb_q.pop_front();
          compare("wb_rd_o", {27'b0, wb_e[36:32]}, {27'b0, wb_rd_i});
          compare("wb_data_o", wb_e[31:0], wb_data_i);
        end
      end
      // a request under back-pressure must not move.
      if (held) begin
        compare("lsu_req_o", 32'd1, {31'b0, lsu_req_i});
        compare("lsu_addr_o", held_req[63:32], lsu_addr_i);
        compare("lsu_wdata_o", held_req[31:0], lsu_wdata_i);
        compare("lsu_width_o", {30'b0, held_req[65:64]}, {30'b0, lsu_width_i});
      end
      held     = lsu_req_i && lsu_bp_i;
      held_req = {lsu_width_i, lsu_addr_i, lsu_wdata_i};
      if (lsu_req_i && !lsu_bp_i) begin
        if (st_q.size() == 0) begin
          unexpected("store request");
        end else begin
          st_e = st_q.pop_front();
          compare("lsu_addr_o", st_e[63:32], lsu_addr_i);
          compare("lsu_wdata_o", st_e[31:0], lsu_wdata_i);
          compare("lsu_width_o", {30'b0, st_e[65:64]}, {30'b0, lsu_width_i});
        end
      end
      if (redirect_i) begin
        if (rd_q.size() == 0) begin
          unexpected("redirect");
        end else begin
          compare("redirect_pc_o", rd_q.pop_front(), redirect_pc_i);
        end
      end
      if (illegal_i) begin
        if (ill_cnt == 0) begin
          unexpected("illegal pulse");
        end else begin
          ill_cnt--;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_rv_core_top.sv
// Testbench top for the RV32I slice; acts as fetch, applies the stimulus table and gives a verdict.
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defs.svh"

module tb_rv_core_top;

  localparam logic [3:0] K_WB = 4'd1;
  localparam logic [3:0] K_ST = 4'd2;
  localparam logic [3:0] K_RD = 4'd4;
  localparam logic [3:0] K_IL = 4'd8;

  logic        clk;
  logic        rst_n_i;
  logic        instr_valid_i;
  logic        instr_ready_o;
  logic [31:0] instr_i;
  logic [31:0] pc_i;
  logic        lsu_bp_i;
  logic        wb_valid_o;
  logic [4:0]  wb_rd_o;
  logic [31:0] wb_data_o;
  logic        redirect_o;
  logic [31:0] redirect_pc_o;
  logic        lsu_req_o;
  logic [31:0] lsu_addr_o;
  logic [31:0] lsu_wdata_o;
  logic [1:0]  lsu_width_o;
  logic        illegal_o;

  logic [31:0] t_insn [64];
  logic [3:0]  t_kind [64];
  logic [4:0]  t_rd [64];
  logic [31:0] t_val [64];
  logic [31:0] t_addr [64];
  logic [1:0]  t_width [64];
  int          t_bp [64];
  int          nrows;
  int          limit;
  int          cycles;
  int          bp_len;
  integer      seed;
  logic [31:0] sq;

  rv_core_top dut0 (.*);

  rv_core_checker chk0 (
    .clk(clk), .rst_n_i(rst_n_i), .instr_ready_i(instr_ready_o), .wb_valid_i(wb_valid_o),
    .wb_rd_i(wb_rd_o), .wb_data_i(wb_data_o), .redirect_i(redirect_o),
    .redirect_pc_i(redirect_pc_o), .lsu_req_i(lsu_req_o), .lsu_addr_i(lsu_addr_o),
    .lsu_wdata_i(lsu_wdata_o), .lsu_width_i(lsu_width_o), .lsu_bp_i(lsu_bp_i),
    .illegal_i(illegal_o)
  );

  // instruction encoders.
  function automatic logic [31:0] r_op(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
  endfunction

  function automatic logic [31:0] i_op(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_op(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OPC_STORE};
  endfunction

  function automatic logic [31:0] b_op(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OPC_BRANCH};
  endfunction

  function automatic logic [31:0] j_op(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OPC_JAL};
  endfunction

  task automatic add_row(input logic [31:0] insn, input logic [3:0] kind, input logic [4:0] rd,
                         input logic [31:0] val, input logic [31:0] addr,
                         input logic [1:0] width, input int bp);
    t_insn[nrows]  = insn;
    t_kind[nrows]  = kind;
    t_rd[nrows]    = rd;
    t_val[nrows]   = val;
    t_addr[nrows]  = addr;
    t_width[nrows] = width;
    t_bp[nrows]    = bp;
    nrows++;
  endtask

  task automatic build_table();
    sq = i_op(12'h055, 5'd0, 3'd0, 5'd20, `RV_OPC_OP_IMM);
    // alu ops, pc of row n is 0x100 + 4n.
    add_row(i_op(12'h123, 5'd0, 3'd0, 5'd1, `RV_OPC_OP_IMM), K_WB, 5'd1, 32'h123, 0, 0, 0);
    add_row(i_op(12'hffb, 5'd0, 3'd0, 5'd2, `RV_OPC_OP_IMM), K_WB, 5'd2, 32'hfffffffb, 0, 0, 0);
    add_row(r_op(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), K_WB, 5'd3, 32'h11e, 0, 0, 0);
    add_row(r_op(7'h20, 5'd2, 5'd1, 3'd0, 5'd4), K_WB, 5'd4, 32'h128, 0, 0, 0);
    add_row(r_op(7'h00, 5'd1, 5'd2, 3'd2, 5'd5), K_WB, 5'd5, 32'h1, 0, 0, 0);
    add_row(r_op(7'h00, 5'd1, 5'd2, 3'd3, 5'd6), K_WB, 5'd6, 32'h0, 0, 0, 0);
    add_row(r_op(7'h00, 5'd2, 5'd1, 3'd4, 5'd7), K_WB, 5'd7, 32'hfffffed8, 0, 0, 0);
    add_row(r_op(7'h00, 5'd2, 5'd1, 3'd6, 5'd8), K_WB, 5'd8, 32'hfffffffb, 0, 0, 0);
    add_row(r_op(7'h00, 5'd2, 5'd1, 3'd7, 5'd9), K_WB, 5'd9, 32'h123, 0, 0, 0);
    add_row(i_op(12'h004, 5'd0, 3'd0, 5'd10, `RV_OPC_OP_IMM), K_WB, 5'd10, 32'h4, 0, 0, 0);
    add_row(r_op(7'h00, 5'd10, 5'd1, 3'd1, 5'd11), K_WB, 5'd11, 32'h1230, 0, 0, 0);
    add_row(r_op(7'h00, 5'd10, 5'd2, 3'd5, 5'd12), K_WB, 5'd12, 32'h0fffffff, 0, 0, 0);
    add_row(r_op(7'h20, 5'd10, 5'd2, 3'd5, 5'd13), K_WB, 5'd13, 32'hffffffff, 0, 0, 0);
    add_row(i_op(12'h401, 5'd2, 3'd5, 5'd14, `RV_OPC_OP_IMM), K_WB, 5'd14, 32'hfffffffd, 0, 0, 0);
    add_row({20'habcde, 5'd15, `RV_OPC_LUI}, K_WB, 5'd15, 32'habcde000, 0, 0, 0);
    add_row({20'h00001, 5'd16, `RV_OPC_AUIPC}, K_WB, 5'd16, 32'h113c, 0, 0, 0);
    add_row(i_op(12'h005, 5'd0, 3'd0, 5'd0, `RV_OPC_OP_IMM), K_WB, 5'd0, 32'h5, 0, 0, 0);
    add_row(r_op(7'h00, 5'd0, 5'd0, 3'd0, 5'd17), K_WB, 5'd17, 32'h0, 0, 0, 0);
    // dependent chain into a store.
    add_row(i_op(12'h007, 5'd17, 3'd0, 5'd18, `RV_OPC_OP_IMM), K_WB, 5'd18, 32'h7, 0, 0, 0);
    add_row(r_op(7'h00, 5'd18, 5'd18, 3'd0, 5'd18), K_WB, 5'd18, 32'he, 0, 0, 0);
    add_row(s_op(12'h008, 5'd18, 5'd10, 3'd2), K_ST, 5'd0, 32'he, 32'hc, 2'd2, 0);
    // back-pressure windows.
    add_row(s_op(12'hfff, 5'd1, 5'd10, 3'd0), K_ST, 5'd0, 32'h123, 32'h3, 2'd0, 3);
    add_row(s_op(12'h002, 5'd2, 5'd1, 3'd1), K_ST, 5'd0, 32'hfffffffb, 32'h125, 2'd1, 2);
    add_row(i_op(12'h001, 5'd1, 3'd0, 5'd19, `RV_OPC_OP_IMM), K_WB, 5'd19, 32'h124, 0, 0, 2);
    add_row(i_op(12'h001, 5'd19, 3'd0, 5'd19, `RV_OPC_OP_IMM), K_WB, 5'd19, 32'h125, 0, 0, 1);
    add_row(s_op(12'h000, 5'd19, 5'd10, 3'd2), K_ST, 5'd0, 32'h125, 32'h4, 2'd2, 3);
    // branches, taken then not taken.
    add_row(b_op(13'd16, 5'd1, 5'd1, 3'd0), K_RD, 5'd0, 0, 32'h178, 0, 0);
    add_row(sq, 4'd0, 0, 0, 0, 0, 0);
    add_row(sq, 4'd0, 0, 0, 0, 0, 0);
    add_row(b_op(13'd16, 5'd2, 5'd1, 3'd0), 4'd0, 0, 0, 0, 0, 0);
    add_row(b_op(13'd16, 5'd2, 5'd1, 3'd1), K_RD, 5'd0, 0, 32'h188, 0, 0);
    add_row(sq, 4'd0, 0, 0, 0, 0, 0);
    add_row(sq, 4'd0, 0, 0, 0, 0, 0);
    add_row(b_op(13'd16, 5'd1, 5'd1, 3'd1), 4'd0, 0, 0, 0, 0, 0);
    add_row(b_op(13'd16, 5'd1, 5'd2, 3'd4), K_RD, 5'd0, 0, 32'h198, 0, 0);
    add_row(sq, 4'd0, 0, 0, 0, 0, 0);
    add_row(sq, 4'd0, 0, 0, 0, 0, 0);
    add_row(b_op(13'd16, 5'd2, 5'd1, 3'd4), 4'd0, 0, 0, 0, 0, 0);
    add_row(b_op(13'd16, 5'd2, 5'd1, 3'd5), K_RD, 5'd0, 0, 32'h1a8, 0, 0);
    add_row(sq, 4'd0, 0, 0, 0, 0, 0);
    add_row(sq, 4'd0, 0, 0, 0, 0, 0);
    add_row(b_op(13'd16, 5'd1, 5'd2, 3'd5), 4'd0, 0, 0, 0, 0, 0);
    add_row(b_op(13'd16, 5'd2, 5'd1, 3'd6), K_RD, 5'd0, 0, 32'h1b8, 0, 0);
    add_row(sq, 4'd0, 0, 0, 0, 0, 0);
    add_row(sq, 4'd0, 0, 0, 0, 0, 0);
    add_row(b_op(13'd16, 5'd1, 5'd2, 3'd6), 4'd0, 0, 0, 0, 0, 0);
    add_row(b_op(13'd16, 5'd1, 5'd2, 3'd7), K_RD, 5'd0, 0, 32'h1c8, 0, 0);
    add_row(sq, 4'd0, 0, 0, 0, 0, 0);
    add_row(sq, 4'd0, 0, 0, 0, 0, 0);
    add_row(b_op(13'd16, 5'd2, 5'd1, 3'd7), 4'd0, 0, 0, 0, 0, 0);
    // jumps write the link value.
    add_row(j_op(21'd32, 5'd21), K_WB | K_RD, 5'd21, 32'h1cc, 32'h1e8, 0, 0);
    add_row(sq, 4'd0, 0, 0, 0, 0, 0);
    add_row(sq, 4'd0, 0, 0, 0, 0, 0);
    add_row(i_op(12'h030, 5'd1, 3'd0, 5'd22, `RV_OPC_JALR), K_WB | K_RD, 5'd22, 32'h1d8,
            32'h152, 0, 0);
    add_row(sq, 4'd0, 0, 0, 0, 0, 0);
    add_row(sq, 4'd0, 0, 0, 0, 0, 0);
    // a load and an unknown word.
    add_row(i_op(12'h000, 5'd1, 3'd2, 5'd23, 7'b0000011), K_IL, 0, 0, 0, 0, 0);
    add_row(32'hffffffff, K_IL, 0, 0, 0, 0, 0);
    add_row(r_op(7'h00, 5'd22, 5'd21, 3'd0, 5'd24), K_WB, 5'd24, 32'h3a4, 0, 0, 0);
  endtask

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    clk           = 1'b0;
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    lsu_bp_i      = 1'b0;
    nrows         = 0;
    limit         = 0;
    cycles        = 0;
    seed          = 32'hd24a_941f;
    build_table();
    limit = nrows * 8 + 50;
    repeat (10) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    @(posedge clk);
    #1;
    for (int i = 0; i < nrows; i++) begin
      instr_i       = t_insn[i];
      pc_i          = 32'h100 + 32'(4 * i);
      instr_valid_i = 1'b1;
      if (t_kind[i] & K_WB) chk0.expect_wb(t_rd[i], t_val[i]);
      if (t_kind[i] & K_ST) chk0.expect_store(t_addr[i], t_val[i], t_width[i]);
      if (t_kind[i] & K_RD) chk0.expect_redirect(t_addr[i]);
      if (t_kind[i] & K_IL) chk0.expect_illegal();
      if (t_bp[i] > 0) begin
        bp_len   = 1 + int'($unsigned($random(seed)) % t_bp[i]);
        lsu_bp_i = 1'b1;
        repeat (bp_len) @(posedge clk);
        #1;
        lsu_bp_i = 1'b0;
      end
      do @(posedge clk); while (!instr_ready_o);
      #1;
    end
    instr_valid_i = 1'b0;
    while (chk0.pending() != 0) @(posedge clk);
    // leave room for stray events.
    repeat (5) @(posedge clk);
    $display("checks=%0d errors=%0d", chk0.checks, chk0.errors);
    if (chk0.errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_core_top.f
+incdir+hdl
hdl/rv_core_pkg.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_pipe_ctrl.sv
hdl/rv_core_top.sv
testbench/rv_core_checker.sv
testbench/tb_rv_core_top.sv

//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal -f rv_core_top.f --top-module tb_rv_core_top \
		-Mdir obj_dir -o sim_tb

run: compile
	./obj_dir/sim_tb | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log
